// ==== common/memWrapPkg.sv ====
//------------------------------------------------
// Shared types of the memory subsystem
// Request, RAM write, CR access, instruction
//------------------------------------------------
`include "memWrap_defs.svh"

package memWrapPkg;

    // Access size of a load or store
    typedef enum logic [1:0] {
        sizeByte = 2'b00,
        sizeHalf = 2'b01,
        sizeWord = 2'b10
    } memSizeT;

    typedef logic [31:0] dataWordT;

    // RV32 R-type field split, MSB first
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instrWordT;

    //------------------------------------------------
    // Core side, Q103H
    //------------------------------------------------
    typedef struct packed {
        logic     rdEn;
        logic     wrEn;
        logic     [31:0] addr;
        dataWordT wrData;           // Register order, value in low bits
        memSizeT  size;
        logic     unsignedLd;       // Zero extend on load
    } dmemReqT;

    //------------------------------------------------
    // Memory side
    //------------------------------------------------
    typedef struct packed {
        logic                          wrEn;
        logic [$clog2(`MEM_WORDS)-1:0] wrAddr;  // Word index
        dataWordT                      wrData;  // Already in its lanes
        logic [3:0]                    byteEn;
    } ramWrT;

    // Control register access, one cycle
    typedef struct packed {
        logic       wrEn;
        logic       rdEn;
        logic [7:0] offset;         // Byte offset in CR region
        dataWordT   wrData;
        logic [3:0] byteEn;
    } crWrT;

endpackage

// ==== common/memWrap_defs.svh ====
//------------------------------------------------
// Memory map of the data port
// Region bounds, memory depth, CR offsets
//------------------------------------------------
`ifndef MEMWRAP_DEFS_SVH
`define MEMWRAP_DEFS_SVH

// Region bounds, inclusive
`define IMEM_FLOOR 32'h0000_0000
`define IMEM_ROOF  32'h0000_3FFF
`define DMEM_FLOOR 32'h0001_0000
`define DMEM_ROOF  32'h0001_3FFF
`define CR_FLOOR   32'h0002_0000
`define CR_ROOF    32'h0002_00FF

`define MEM_WORDS  4096           // Words per memory, 16 KB

//------------------------------------------------
// Control register offsets
//------------------------------------------------
`define CR_LED     8'h00          // RW, 10 bits
`define CR_SEG7_0  8'h04          // RW, 8 bits each
`define CR_SEG7_1  8'h08
`define CR_SEG7_2  8'h0C
`define CR_SEG7_3  8'h10
`define CR_SEG7_4  8'h14
`define CR_SEG7_5  8'h18
`define CR_BUTTON  8'h20          // RO, 2 bits
`define CR_SWITCH  8'h24          // RO, 10 bits

`endif

// ==== crMem/crMem.sv ====
//------------------------------------------------
// Control registers of the board
// LED and seven-segment registers, input sync,
// registered read mux
//------------------------------------------------
`include "memWrap_defs.svh"

module crMem (
    input  logic                 Clk,
    input  logic                 rstN,
    input  memWrapPkg::crWrT     req,
    output memWrapPkg::dataWordT rdData,
    input  logic [1:0]           button,
    input  logic [9:0]           switch,
    output logic [9:0]           led,
    output logic [5:0][7:0]      seg7
);
    import memWrapPkg::*;

    // Display register offsets, digit order
    localparam logic [7:0] segOff [6] = '{`CR_SEG7_0, `CR_SEG7_1, `CR_SEG7_2,
                                          `CR_SEG7_3, `CR_SEG7_4, `CR_SEG7_5};

    logic [7:0] wordOff;
    logic [1:0] buttonMeta;
    logic [1:0] buttonSync;
    logic [9:0] switchMeta;
    logic [9:0] switchSync;
    dataWordT   rdMux;

    assign wordOff = {req.offset[7:2], 2'b00};  // Lane bits dropped, byteEn picks lanes

    //------------------------------------------------
    // Board input synchronizers
    //------------------------------------------------
    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            buttonMeta <= '0;
            buttonSync <= '0;
            switchMeta <= '0;
            switchSync <= '0;
        end else begin
            buttonMeta <= button;       // First stage
            buttonSync <= buttonMeta;
            switchMeta <= switch;
            switchSync <= switchMeta;
        end
    end

    //------------------------------------------------
    // Writable registers
    //------------------------------------------------
    // Segments active low, reset blanks all digits
    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            led  <= '0;
            seg7 <= {6{8'hFF}};
        end else if (req.wrEn) begin
            if (wordOff == `CR_LED) begin
                if (req.byteEn[0]) begin
                    led[7:0] <= req.wrData[7:0];
                end
                if (req.byteEn[1]) begin
                    led[9:8] <= req.wrData[9:8];    // Upper two LEDs in lane 1
                end
            end
            for (int i = 0; i < 6; i++) begin
                if (wordOff == segOff[i] && req.byteEn[0]) begin
                    seg7[i] <= req.wrData[7:0];
                end
            end
            // Button and switch offsets fall through, read only
        end
    end

    //------------------------------------------------
    // Read mux
    //------------------------------------------------
    always_comb begin
        case (wordOff)
            `CR_LED:    rdMux = {22'b0, led};
            `CR_SEG7_0: rdMux = {24'b0, seg7[0]};
            `CR_SEG7_1: rdMux = {24'b0, seg7[1]};
            `CR_SEG7_2: rdMux = {24'b0, seg7[2]};
            `CR_SEG7_3: rdMux = {24'b0, seg7[3]};
            `CR_SEG7_4: rdMux = {24'b0, seg7[4]};
            `CR_SEG7_5: rdMux = {24'b0, seg7[5]};
            `CR_BUTTON: rdMux = {30'b0, buttonSync};
            `CR_SWITCH: rdMux = {22'b0, switchSync};
            default:    rdMux = '0;                 // Unknown offset
        endcase
    end

    // Sync read, data in Q104H
    always_ff @(posedge Clk) begin
        if (req.rdEn) begin
            rdData <= rdMux;
        end
    end

endmodule

// ==== memWrap.f ====
+incdir+common
common/memWrapPkg.sv
source/syncRam.sv
source/loadStoreAlign.sv
crMem/crMem.sv
source/memWrap.sv
testbench/memWrapClk.sv
testbench/memWrap_props.sv
testbench/memWrapTb.sv

// ==== runSim.sh ====
#!/bin/sh
# Build and run memWrapTb with Verilator, verdict taken from sim.log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module memWrapTb -f memWrap.f \
    -Mdir obj_dir > sim.log 2>&1 \
    && ./obj_dir/VmemWrapTb >> sim.log 2>&1 \
    || { cat sim.log; echo "Build or simulation failed"; exit 1; }

cat sim.log
grep -q "ERRORS FOUND" sim.log && exit 1 || exit 0

// ==== source/loadStoreAlign.sv ====
//------------------------------------------------
// Data port aligner
// Region decode, store lane shift and byte enables,
// Q104H state, read select and load extension
//------------------------------------------------
`include "memWrap_defs.svh"

module loadStoreAlign (
    input  logic                 Clk,
    input  logic                 rstN,
    input  memWrapPkg::dmemReqT  req,
    output memWrapPkg::ramWrT    imemWr,
    output memWrapPkg::ramWrT    dmemWr,
    output logic                 dmemRdEn,
    input  memWrapPkg::dataWordT dmemRdData,
    output memWrapPkg::crWrT     crReq,
    input  memWrapPkg::dataWordT crRdData,
    output memWrapPkg::dataWordT rdRsp
);
    import memWrapPkg::*;

    localparam int addrBits = $clog2(`MEM_WORDS);

    // Q103H decode
    logic       matchImemQ103H;
    logic       matchDmemQ103H;
    logic       matchCrQ103H;
    logic [1:0] offQ103H;
    logic [3:0] beBaseQ103H;
    logic [3:0] byteEnQ103H;
    dataWordT   wrLanesQ103H;

    // Q104H state
    logic       rdDmemQ104H;
    logic       rdCrQ104H;
    logic [1:0] offQ104H;
    memSizeT    sizeQ104H;
    logic       unsignedQ104H;
    dataWordT   selQ104H;
    dataWordT   shiftQ104H;

    // Single unsigned compare, wraps below floor
    function automatic logic inRegion(input logic [31:0] addr,
                                      input logic [31:0] floor,
                                      input logic [31:0] roof);
        logic [31:0] rel;
        rel = addr - floor;
        return rel <= (roof - floor);
    endfunction

    //------------------------------------------------
    // Q103H, region decode and store lanes
    //------------------------------------------------
    assign matchImemQ103H = inRegion(req.addr, `IMEM_FLOOR, `IMEM_ROOF);
    assign matchDmemQ103H = inRegion(req.addr, `DMEM_FLOOR, `DMEM_ROOF);
    assign matchCrQ103H   = inRegion(req.addr, `CR_FLOOR, `CR_ROOF);
    assign offQ103H       = req.addr[1:0];  // Byte offset in word

    always_comb begin
        case (req.size)
            sizeByte: beBaseQ103H = 4'b0001;
            sizeHalf: beBaseQ103H = 4'b0011;
            default:  beBaseQ103H = 4'b1111;
        endcase
        byteEnQ103H  = beBaseQ103H << offQ103H;             // Natural alignment assumed
        wrLanesQ103H = req.wrData << {offQ103H, 3'b000};
    end

    // Enables to exactly one target
    always_comb begin
        imemWr.wrEn   = req.wrEn & matchImemQ103H;           // Loader path, write only
        imemWr.wrAddr = req.addr[addrBits+1:2];
        imemWr.wrData = wrLanesQ103H;
        imemWr.byteEn = byteEnQ103H;

        dmemWr.wrEn   = req.wrEn & matchDmemQ103H;
        dmemWr.wrAddr = req.addr[addrBits+1:2];               // Also the read address
        dmemWr.wrData = wrLanesQ103H;
        dmemWr.byteEn = byteEnQ103H;
        dmemRdEn      = req.rdEn & matchDmemQ103H;

        crReq.wrEn    = req.wrEn & matchCrQ103H;
        crReq.rdEn    = req.rdEn & matchCrQ103H;
        crReq.offset  = req.addr[7:0];
        crReq.wrData  = wrLanesQ103H;
        crReq.byteEn  = byteEnQ103H;
    end

    //------------------------------------------------
    // Q103H to Q104H
    //------------------------------------------------
    // Flags set only for loads, stores leave them clear
    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            rdDmemQ104H   <= 1'b0;
            rdCrQ104H     <= 1'b0;
            offQ104H      <= 2'b00;
            sizeQ104H     <= sizeByte;
            unsignedQ104H <= 1'b0;
        end else begin
            rdDmemQ104H   <= req.rdEn & matchDmemQ103H;
            rdCrQ104H     <= req.rdEn & matchCrQ103H;
            offQ104H      <= offQ103H;
            sizeQ104H     <= req.size;
            unsignedQ104H <= req.unsignedLd;
        end
    end

    //------------------------------------------------
    // Q104H, select, shift down, extend
    //------------------------------------------------
    always_comb begin
        if (rdDmemQ104H) begin
            selQ104H = dmemRdData;
        end else if (rdCrQ104H) begin
            selQ104H = crRdData;
        end else begin
            selQ104H = '0;                                    // Idle, store, IMEM or unmapped
        end
        shiftQ104H = selQ104H >> {offQ104H, 3'b000};
        case (sizeQ104H)
            sizeByte: rdRsp = {{24{~unsignedQ104H & shiftQ104H[7]}}, shiftQ104H[7:0]};
            sizeHalf: rdRsp = {{16{~unsignedQ104H & shiftQ104H[15]}}, shiftQ104H[15:0]};
            default:  rdRsp = shiftQ104H;
        endcase
    end

endmodule

// ==== source/memWrap.sv ====
//------------------------------------------------
// Memory subsystem top level
// Aligner, instruction and data RAMs, CR block
//------------------------------------------------
`include "memWrap_defs.svh"

module memWrap (
    input  logic                  Clk,
    input  logic                  rstN,
    input  logic [31:0]           pcQ100H,          // Fetch, Q100H
    output memWrapPkg::instrWordT instructionQ101H,
    input  memWrapPkg::dmemReqT   dmemReqQ103H,     // Load or store, Q103H
    output memWrapPkg::dataWordT  dmemRdRspQ104H,
    // Board
    input  logic [1:0]            button,
    input  logic [9:0]            switch,
    output logic [9:0]            led,
    output logic [5:0][7:0]       seg7              // Active low
);
    import memWrapPkg::*;

    ramWrT    imemWr;
    ramWrT    dmemWr;
    logic     dmemRdEn;
    dataWordT dmemRdData;
    crWrT     crReq;
    dataWordT crRdData;

    //------------------------------------------------
    // Data port routing
    //------------------------------------------------
    loadStoreAlign lsAlign (
        .Clk        (Clk),
        .rstN       (rstN),
        .req        (dmemReqQ103H),
        .imemWr     (imemWr),
        .dmemWr     (dmemWr),
        .dmemRdEn   (dmemRdEn),
        .dmemRdData (dmemRdData),
        .crReq      (crReq),
        .crRdData   (crRdData),
        .rdRsp      (dmemRdRspQ104H)
    );

    // Fetch every cycle, written only by the data port
    syncRam #(.wordT(instrWordT), .depth(`MEM_WORDS)) iMem (
        .Clk    (Clk),
        .rdAddr (pcQ100H[$clog2(`MEM_WORDS)+1:2]),
        .rdEn   (1'b1),
        .rdData (instructionQ101H),
        .wr     (imemWr)
    );

    syncRam #(.wordT(dataWordT), .depth(`MEM_WORDS)) dMem (
        .Clk    (Clk),
        .rdAddr (dmemWr.wrAddr),                    // Shared word index
        .rdEn   (dmemRdEn),
        .rdData (dmemRdData),
        .wr     (dmemWr)
    );

    crMem crRegs (
        .Clk    (Clk),
        .rstN   (rstN),
        .req    (crReq),
        .rdData (crRdData),
        .button (button),
        .switch (switch),
        .led    (led),
        .seg7   (seg7)
    );

endmodule

// ==== source/syncRam.sv ====
//------------------------------------------------
// Synchronous RAM, one read and one write port
// Byte enables on write, word type as parameter
//------------------------------------------------
module syncRam #(
    parameter type wordT = memWrapPkg::dataWordT,
    parameter int  depth = 4096
) (
    input  logic                     Clk,
    input  logic [$clog2(depth)-1:0] rdAddr,
    input  logic                     rdEn,
    output wordT                     rdData,
    input  memWrapPkg::ramWrT        wr
);

    localparam int wordBits = $bits(wordT);
    localparam int numBytes = wordBits / 8;

    // Raw storage, no reset on contents
    logic [wordBits-1:0] mem [depth];

    //------------------------------------------------
    // Write port
    //------------------------------------------------
    always_ff @(posedge Clk) begin
        if (wr.wrEn) begin
            for (int b = 0; b < numBytes; b++) begin
                if (wr.byteEn[b]) begin
                    mem[wr.wrAddr][8*b +: 8] <= wr.wrData[8*b +: 8];  // Lane b only
                end
            end
        end
    end

    //------------------------------------------------
    // Read port
    //------------------------------------------------
    // Old data on same-address collision
    always_ff @(posedge Clk) begin
        if (rdEn) begin
            rdData <= wordT'(mem[rdAddr]);
        end
    end

endmodule

// ==== testbench/memWrapClk.sv ====
//------------------------------------------------
// Clock and reset generator of the testbench
//------------------------------------------------
module memWrapClk (
    output logic Clk,
    output logic rstN
);

    initial begin
        Clk = 1'b0;
        forever #10 Clk = ~Clk;             // Period 20
    end

    // Reset held over two rising edges, released on a falling edge
    initial begin
        rstN = 1'b0;
        repeat (2) @(negedge Clk);
        rstN = 1'b1;
    end

endmodule

// ==== testbench/memWrapTb.sv ====
//------------------------------------------------
// Testbench of the memory subsystem
// Directed tests, memory reference model,
// cycle timeout and closing summary
//------------------------------------------------
`include "memWrap_defs.svh"

module memWrapTb;
    import memWrapPkg::*;

    localparam int cycleLimit = 3000;       // About twice the test length

    // Unmapped addresses that partly alias low words
    localparam logic [31:0] holes [6] = '{32'h0000_4000, 32'h0000_FFFC, 32'h0001_4000,
                                          32'h0002_0100, 32'h8000_0000, 32'hFFFF_FFFC};

    logic            Clk;
    logic            rstN;
    logic [31:0]     pcQ100H;
    instrWordT       instructionQ101H;
    dmemReqT         dmemReqQ103H;
    dataWordT        dmemRdRspQ104H;
    logic [1:0]      button;
    logic [9:0]      switch;
    logic [9:0]      led;
    logic [5:0][7:0] seg7;

    logic [31:0] dmemModel [`MEM_WORDS];    // Expected DMEM words
    logic [31:0] imemModel [256];           // Loaded program words
    logic [31:0] lcgState;
    int          checkCount;
    int          errorCount;
    int          testCount;
    int          cycleCount;

    memWrapClk clkGen (.Clk(Clk), .rstN(rstN));

    memWrap DUT (
        .Clk              (Clk),
        .rstN             (rstN),
        .pcQ100H          (pcQ100H),
        .instructionQ101H (instructionQ101H),
        .dmemReqQ103H     (dmemReqQ103H),
        .dmemRdRspQ104H   (dmemRdRspQ104H),
        .button           (button),
        .switch           (switch),
        .led              (led),
        .seg7             (seg7)
    );

    // Run limit
    always @(posedge Clk) begin
        cycleCount++;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout, run did not finish within %0d cycles", cycleLimit);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    //------------------------------------------------
    // Model helpers
    //------------------------------------------------
    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic int numBytes(input memSizeT size);
        return (size == sizeByte) ? 1 : (size == sizeHalf) ? 2 : 4;
    endfunction

    // Value bytes land in lanes starting at the byte offset
    function automatic void applyStore(input logic [31:0] addr, input logic [31:0] data,
                                       input memSizeT size);
        logic [31:0] word;
        int          off;
        word = dmemModel[addr[13:2]];
        off  = int'(addr[1:0]);
        for (int k = 0; k < numBytes(size); k++) begin
            word[8*(off+k) +: 8] = data[8*k +: 8];
        end
        dmemModel[addr[13:2]] = word;
    endfunction

    function automatic logic [31:0] loadExpect(input logic [31:0] word, input logic [1:0] off,
                                               input memSizeT size, input logic uns);
        logic [7:0]  lane;
        logic [15:0] pair;
        case (off)
            2'd0:    lane = word[7:0];
            2'd1:    lane = word[15:8];
            2'd2:    lane = word[23:16];
            default: lane = word[31:24];
        endcase
        pair = off[1] ? word[31:16] : word[15:0];   // Upper or lower half
        case (size)
            sizeByte: return uns ? {24'b0, lane} : {{24{lane[7]}}, lane};
            sizeHalf: return uns ? {16'b0, pair} : {{16{pair[15]}}, pair};
            default:  return word;
        endcase
    endfunction

    function automatic logic [31:0] crAddr(input logic [7:0] off);
        return `CR_FLOOR | {24'b0, off};
    endfunction

    //------------------------------------------------
    // Drive and check tasks
    //------------------------------------------------
    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        checkCount++;
        assert (got == exp) else begin
            $display("ERROR %s got 0x%08h expected 0x%08h", name, got, exp);
            errorCount++;
        end
    endtask

    task automatic doStore(input logic [31:0] addr, input logic [31:0] data,
                           input memSizeT size);
        dmemReqQ103H        = '0;
        dmemReqQ103H.wrEn   = 1'b1;
        dmemReqQ103H.addr   = addr;
        dmemReqQ103H.wrData = data;
        dmemReqQ103H.size   = size;
        if (addr >= `DMEM_FLOOR && addr <= `DMEM_ROOF) begin
            applyStore(addr, data, size);
        end
        @(negedge Clk);                     // Written at the edge in between
        dmemReqQ103H = '0;
    endtask

    // Response checked exactly one clock after issue
    task automatic loadAndCheck(input string name, input logic [31:0] addr,
                                input memSizeT size, input logic uns, input logic [31:0] exp);
        dmemReqQ103H            = '0;
        dmemReqQ103H.rdEn       = 1'b1;
        dmemReqQ103H.addr       = addr;
        dmemReqQ103H.size       = size;
        dmemReqQ103H.unsignedLd = uns;
        @(negedge Clk);
        checkValue(name, dmemRdRspQ104H, exp);
        dmemReqQ103H = '0;
    endtask

    // RV32 field positions
    task automatic fetchAndCheck(input int idx);
        logic [31:0] exp;
        exp     = imemModel[idx];
        pcQ100H = 32'(idx) << 2;
        @(negedge Clk);
        checkValue("opcode", {25'b0, instructionQ101H.opcode}, {25'b0, exp[6:0]});
        checkValue("rd", {27'b0, instructionQ101H.rd}, {27'b0, exp[11:7]});
        checkValue("funct3", {29'b0, instructionQ101H.funct3}, {29'b0, exp[14:12]});
        checkValue("rs1", {27'b0, instructionQ101H.rs1}, {27'b0, exp[19:15]});
        checkValue("rs2", {27'b0, instructionQ101H.rs2}, {27'b0, exp[24:20]});
        checkValue("funct7", {25'b0, instructionQ101H.funct7}, {25'b0, exp[31:25]});
    endtask

    task automatic checkHeld(input logic [9:0] ledBefore, input logic [5:0][7:0] segBefore);
        checkValue("led", {22'b0, led}, {22'b0, ledBefore});
        checkValue("seg7[3:0]", seg7[3:0], segBefore[3:0]);
        checkValue("seg7[5:4]", {16'b0, seg7[5:4]}, {16'b0, segBefore[5:4]});
    endtask

    task automatic endTest(input string name, input int errorsAtStart);
        testCount++;
        $display("Test %s done, %0d errors", name, errorCount - errorsAtStart);
    endtask

    //------------------------------------------------
    // Tests
    //------------------------------------------------
    task automatic testReset();
        int startErr;
        startErr = errorCount;
        checkValue("led", {22'b0, led}, 32'h0);
        for (int i = 0; i < 6; i++) begin
            checkValue("seg7", {24'b0, seg7[i]}, 32'hFF);   // Blank digit
        end
        checkValue("dmemRdRspQ104H", dmemRdRspQ104H, 32'h0);
        endTest("reset values", startErr);
    endtask

    task automatic testDataWords();
        int          startErr;
        logic [31:0] addrQ [$];
        logic [31:0] addr;
        startErr = errorCount;
        for (int i = 0; i < 256; i++) begin
            addr = `DMEM_FLOOR + (nextRand() & 32'h0000_3FFC);
            addrQ.push_back(addr);
            doStore(addr, nextRand(), sizeWord);
        end
        foreach (addrQ[i]) begin            // Back to back loads one per cycle
            loadAndCheck("dmemRdRspQ104H", addrQ[i], sizeWord, 1'b0, dmemModel[addrQ[i][13:2]]);
        end
        // Consecutive stores to one word leave a lane each, then an immediate read
        addr = `DMEM_FLOOR + (nextRand() & 32'h0000_3FFC);
        doStore(addr, nextRand(), sizeWord);
        doStore(addr, nextRand(), sizeByte);
        doStore(addr + 32'd2, nextRand(), sizeHalf);
        loadAndCheck("dmemRdRspQ104H", addr, sizeWord, 1'b0, dmemModel[addr[13:2]]);
        endTest("data words", startErr);
    endtask

    task automatic testSubWord();
        int          startErr;
        logic [31:0] base;
        logic [31:0] addr;
        startErr = errorCount;
        for (int w = 0; w < 16; w++) begin
            base = `DMEM_FLOOR + (nextRand() & 32'h0000_3FFC);
            doStore(base, nextRand(), sizeWord);
            for (int off = 0; off < 4; off++) begin
                addr = base + 32'(off);
                doStore(addr, nextRand(), sizeByte);
                loadAndCheck("dmemRdRspQ104H", base, sizeWord, 1'b0, dmemModel[base[13:2]]);
                for (int u = 0; u < 2; u++) begin       // Signed first
                    loadAndCheck("dmemRdRspQ104H", addr, sizeByte, u[0],
                                 loadExpect(dmemModel[base[13:2]], addr[1:0], sizeByte, u[0]));
                end
            end
            for (int off = 0; off < 4; off += 2) begin
                addr = base + 32'(off);
                doStore(addr, nextRand(), sizeHalf);
                loadAndCheck("dmemRdRspQ104H", base, sizeWord, 1'b0, dmemModel[base[13:2]]);
                for (int u = 0; u < 2; u++) begin
                    loadAndCheck("dmemRdRspQ104H", addr, sizeHalf, u[0],
                                 loadExpect(dmemModel[base[13:2]], addr[1:0], sizeHalf, u[0]));
                end
            end
        end
        endTest("byte and half", startErr);
    endtask

    task automatic testInstrMem();
        int          startErr;
        logic [31:0] data;
        startErr = errorCount;
        for (int i = 0; i < 256; i++) begin     // Program load through the data port
            data         = nextRand();
            imemModel[i] = data;
            doStore(32'(i) << 2, data, sizeWord);
        end
        for (int i = 0; i < 256; i++) begin
            fetchAndCheck(i);
        end
        loadAndCheck("dmemRdRspQ104H", `IMEM_FLOOR, sizeWord, 1'b0, 32'h0);
        loadAndCheck("dmemRdRspQ104H", 32'h0000_0104, sizeWord, 1'b0, 32'h0);
        endTest("instruction memory", startErr);
    endtask

    task automatic testCtrlRegs();
        int              startErr;
        logic [31:0]     data;
        logic [7:0]      off;
        logic [9:0]      ledBefore;
        logic [5:0][7:0] segBefore;
        startErr = errorCount;
        data     = nextRand();
        doStore(crAddr(`CR_LED), data, sizeWord);
        checkValue("led", {22'b0, led}, {22'b0, data[9:0]});
        loadAndCheck("dmemRdRspQ104H", crAddr(`CR_LED), sizeWord, 1'b0, {22'b0, data[9:0]});
        for (int i = 0; i < 6; i++) begin
            off  = `CR_SEG7_0 + 8'(4 * i);      // One word per digit
            data = nextRand();
            doStore(crAddr(off), data, sizeByte);
            checkValue("seg7", {24'b0, seg7[i]}, {24'b0, data[7:0]});
            loadAndCheck("dmemRdRspQ104H", crAddr(off), sizeWord, 1'b0, {24'b0, data[7:0]});
        end
        // Read-only offset
        ledBefore = led;
        segBefore = seg7;
        doStore(crAddr(`CR_BUTTON), 32'hFFFF_FFFF, sizeWord);
        checkHeld(ledBefore, segBefore);
        loadAndCheck("dmemRdRspQ104H", crAddr(`CR_BUTTON), sizeWord, 1'b0, {30'b0, button});
        for (int n = 0; n < 8; n++) begin
            data   = nextRand();
            button = data[1:0];
            switch = data[17:8];
            repeat (3) @(negedge Clk);          // Past the two-flop sync
            loadAndCheck("dmemRdRspQ104H", crAddr(`CR_BUTTON), sizeWord, 1'b0,
                         {30'b0, data[1:0]});
            loadAndCheck("dmemRdRspQ104H", crAddr(`CR_SWITCH), sizeWord, 1'b0,
                         {22'b0, data[17:8]});
        end
        endTest("control registers", startErr);
    endtask

    task automatic testUnmapped();
        int              startErr;
        logic [9:0]      ledBefore;
        logic [5:0][7:0] segBefore;
        startErr = errorCount;
        doStore(`DMEM_FLOOR, nextRand(), sizeWord);     // Known word at DMEM index 0
        for (int i = 0; i < 6; i++) begin
            ledBefore = led;
            segBefore = seg7;
            doStore(holes[i], nextRand(), sizeWord);
            checkHeld(ledBefore, segBefore);
            loadAndCheck("dmemRdRspQ104H", holes[i], sizeWord, 1'b0, 32'h0);
        end
        loadAndCheck("dmemRdRspQ104H", `DMEM_FLOOR, sizeWord, 1'b0, dmemModel[0]);
        fetchAndCheck(0);                       // IMEM word 0 untouched
        endTest("unmapped", startErr);
    endtask

    //------------------------------------------------
    // Sequence and summary
    //------------------------------------------------
    initial begin
        pcQ100H      = '0;
        dmemReqQ103H = '0;
        button       = '0;
        switch       = '0;
        lcgState     = 32'd35;                  // Seed
        checkCount   = 0;
        errorCount   = 0;
        testCount    = 0;
        cycleCount   = 0;
        @(posedge rstN);
        @(negedge Clk);
        testReset();
        testDataWords();
        testSubWord();
        testInstrMem();
        testCtrlRegs();
        testUnmapped();
        $display("Summary: %0d tests, %0d checks, %0d errors", testCount, checkCount,
                 errorCount);
        if (errorCount == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== testbench/memWrap_props.sv ====
//------------------------------------------------
// Concurrent checks on the data port aligner
// Region exclusion, store byte enables, idle response
//------------------------------------------------
module memWrapProps (
    input  logic                 Clk,
    input  logic                 rstN,
    input  memWrapPkg::dmemReqT  req,
    input  memWrapPkg::ramWrT    imemWr,
    input  memWrapPkg::ramWrT    dmemWr,
    input  logic                 dmemRdEn,
    input  memWrapPkg::crWrT     crReq,
    input  memWrapPkg::dataWordT rdRsp
);
    import memWrapPkg::*;

    logic       imemActive;
    logic       dmemActive;
    logic       crActive;
    logic       storeActive;
    logic [3:0] beWant;
    int         laneCount;

    assign imemActive  = imemWr.wrEn;               // IMEM has no data port read
    assign dmemActive  = dmemWr.wrEn | dmemRdEn;
    assign crActive    = crReq.wrEn | crReq.rdEn;
    assign storeActive = imemWr.wrEn | dmemWr.wrEn | crReq.wrEn;

    // Enabled lanes start at the byte offset and span the access size
    always_comb begin
        case (req.size)
            sizeByte: laneCount = 1;
            sizeHalf: laneCount = 2;
            default:  laneCount = 4;
        endcase
        for (int k = 0; k < 4; k++) begin
            beWant[k] = (k >= int'(req.addr[1:0])) && (k < int'(req.addr[1:0]) + laneCount);
        end
    end

    oneRegion: assert property (@(posedge Clk) disable iff (!rstN)
        $onehot0({imemActive, dmemActive, crActive}))
        else $error("More than one region enabled in one cycle");

    // Same lanes on every target
    byteEnSize: assert property (@(posedge Clk) disable iff (!rstN)
        storeActive |-> dmemWr.byteEn == beWant)
        else $error("Store byte enables do not match the access size and offset");

    // Q104H output of a cycle that follows no load
    idleRsp: assert property (@(posedge Clk) disable iff (!rstN)
        !$past(req.rdEn) |-> rdRsp == '0)
        else $error("Load response not zero after a cycle without a load");

endmodule

bind loadStoreAlign memWrapProps props (
    .Clk      (Clk),
    .rstN     (rstN),
    .req      (req),
    .imemWr   (imemWr),
    .dmemWr   (dmemWr),
    .dmemRdEn (dmemRdEn),
    .crReq    (crReq),
    .rdRsp    (rdRsp)
);
